//--- filelist.f
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_imm_gen.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_exec_core.sv
verif/rv_exec_assertions.sv
verif/rv_exec_tb.sv

//--- verif/rv_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

	localparam int NUM_INST       = 2000;
	localparam int TIMEOUT_CYCLES = NUM_INST + 100;

	logic                  clk_i;
	logic                  arst_n_i;
	logic                  inst_valid_i;
	logic [31:0]           inst_i;
	logic [31:0]           pc_i;
	logic [31:0]           mem_rdata_i;
	rv_core_pkg::mem_req_t mem_req_o;
	rv_core_pkg::wb_t      wb_o;

	logic [31:0]           lfsr_state = 32'hea48a113;
	logic [31:0]           regs [32];
	logic [31:0]           mem [256];
	logic [31:0]           model_pc;
	logic                  store_pending;
	logic [7:0]            store_idx;
	logic [31:0]           store_word;
	int                    cycle_count = 0;
	rv_core_pkg::wb_t      exp_wb_q [$];
	rv_core_pkg::mem_req_t exp_mem_q [$];

	rv_exec_core u_dut (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.mem_rdata_i  (mem_rdata_i),
		.mem_req_o    (mem_req_o),
		.wb_o         (wb_o)
	);

	bind rv_exec_core rv_exec_assertions u_assertions (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.mem_req_i (mem_req_o),
		.wb_i      (wb_o)
	);

	always #2 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles without finishing the instruction stream", cycle_count);
			$display("Done: errors found");
			$fatal(1, "Cycle limit reached");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] res;
		case (f3)
			3'b000: res = alt ? (a - b) : (a + b);
			3'b001: res = a << b[4:0];
			3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: res = (a < b) ? 32'd1 : 32'd0;
			3'b100: res = a ^ b;
			3'b101: begin
				if (alt) begin
					res = $signed(a) >>> b[4:0];
				end else begin
					res = a >> b[4:0];
				end
			end
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		return res;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [1:0] off,
		input logic [31:0] word);
		logic [31:0] lane;
		lane = word >> (8 * off); // Little endian, lowest address in the low byte
		case (f3)
			3'b000: return {{24{lane[7]}}, lane[7:0]};
			3'b001: return {{16{lane[15]}}, lane[15:0]};
			3'b100: return {24'b0, lane[7:0]};
			3'b101: return {16'b0, lane[15:0]};
			default: return word;
		endcase
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] data,
		input logic [1:0] width, input logic [1:0] off);
		logic [31:0] mask;
		case (width)
			2'b00: mask = 32'h0000_00ff;
			2'b01: mask = 32'h0000_ffff;
			default: mask = 32'hffff_ffff;
		endcase
		mask = mask << (8 * off);
		return (old & ~mask) | ((data << (8 * off)) & mask);
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Run stopped at %0t", $time);
	endtask

	task automatic check_wb(input rv_core_pkg::wb_t exp, input rv_core_pkg::wb_t act);
		logic bad;
		bad = (act.valid !== exp.valid);
		if (exp.valid) begin
			bad = bad || (act.en !== exp.en) || (act.npc !== exp.npc);
			if (exp.en) begin
				bad = bad || (act.rd !== exp.rd) || (act.data !== exp.data);
			end
		end
		if (bad) begin
			stop_with_failure($sformatf("MISMATCH wb_o expected %h got %h", exp, act));
		end
	endtask

	task automatic check_mem(input rv_core_pkg::mem_req_t exp, input rv_core_pkg::mem_req_t act);
		logic bad;
		bad = (act.read !== exp.read) || (act.write !== exp.write);
		if (exp.read || exp.write) begin
			bad = bad || (act.addr !== exp.addr) || (act.width !== exp.width);
		end
		if (exp.read) begin
			bad = bad || (act.sign !== exp.sign);
		end
		if (exp.write) begin
			bad = bad || (act.wdata !== exp.wdata);
		end
		if (bad) begin
			stop_with_failure($sformatf("MISMATCH mem_req_o expected %h got %h", exp, act));
		end
	endtask

	task automatic issue_random_inst();
		logic [3:0]            sel;
		logic [4:0]            rd;
		logic [4:0]            rs1;
		logic [4:0]            rs2;
		logic [2:0]            f3;
		logic                  alt;
		logic [19:0]           rnd;
		logic [31:0]           imm;
		logic [31:0]           res;
		logic                  wr;
		rv_isa_pkg::opcode_e   opc;
		rv_core_pkg::wb_t      ew;
		rv_core_pkg::mem_req_t em;

		sel = 4'(rand_bits(4));
		rd  = 5'(rand_bits(5));
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		f3  = 3'(rand_bits(3));
		alt = 1'(rand_bits(1));
		rnd = 20'(rand_bits(20));
		imm = {{20{rnd[11]}}, rnd[11:0]};
		ew = '0;
		em = '0;
		ew.valid = 1'b1;
		ew.npc = model_pc + 32'd4;
		wr = 1'b1;
		res = '0;

		case (sel)
			4'd0, 4'd1, 4'd2: opc = rv_isa_pkg::OPC_OP;
			4'd3, 4'd4, 4'd5: opc = rv_isa_pkg::OPC_OP_IMM;
			4'd6:             opc = rv_isa_pkg::OPC_LUI;
			4'd7:             opc = rv_isa_pkg::OPC_AUIPC;
			4'd8, 4'd9:       opc = rv_isa_pkg::OPC_LOAD;
			4'd10, 4'd11:     opc = rv_isa_pkg::OPC_STORE;
			4'd12:            opc = rv_isa_pkg::OPC_BRANCH;
			4'd13:            opc = rv_isa_pkg::OPC_JAL;
			4'd14:            opc = rv_isa_pkg::OPC_JALR;
			default:          opc = rv_isa_pkg::OPC_SYSTEM;
		endcase

		// Only results that are always word aligned may land in the base register x31
		if ((rd == 5'd31) && (opc != rv_isa_pkg::OPC_LUI) && (opc != rv_isa_pkg::OPC_AUIPC) &&
			(opc != rv_isa_pkg::OPC_JAL) && (opc != rv_isa_pkg::OPC_JALR)) begin
			rd = 5'd30;
		end

		case (opc)
			rv_isa_pkg::OPC_OP: begin
				alt = alt && ((f3 == 3'b000) || (f3 == 3'b101));
				inst_i = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc};
				res = alu_model(f3, alt, regs[rs1], regs[rs2]);
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				alt = alt && (f3 == 3'b101);
				if ((f3 == 3'b001) || (f3 == 3'b101)) begin
					imm = {20'b0, 1'b0, alt, 5'b0, rnd[4:0]}; // Shift amount form
				end
				inst_i = {imm[11:0], rs1, f3, rd, opc};
				res = alu_model(f3, alt, regs[rs1], imm);
			end
			rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
				imm = {rnd, 12'b0};
				inst_i = {imm[31:12], rd, opc};
				res = (opc == rv_isa_pkg::OPC_LUI) ? imm : (model_pc + imm);
			end
			rv_isa_pkg::OPC_LOAD: begin
				rs1 = 5'd31;
				if ((f3 == 3'b011) || (f3[2:1] == 2'b11)) begin
					f3 = 3'b010;
				end
				if (f3[1]) begin
					imm[1:0] = 2'b00;
				end else if (f3[0]) begin
					imm[0] = 1'b0;
				end
				inst_i = {imm[11:0], rs1, f3, rd, opc};
				em.read = 1'b1;
				em.addr = regs[31] + imm;
				em.width = rv_isa_pkg::mem_width_e'(f3[1:0]);
				em.sign = ~f3[2];
				res = load_model(f3, em.addr[1:0], mem[em.addr[9:2]]);
			end
			rv_isa_pkg::OPC_STORE: begin
				rs1 = 5'd31;
				f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
				if (f3[1]) begin
					imm[1:0] = 2'b00;
				end else if (f3[0]) begin
					imm[0] = 1'b0;
				end
				inst_i = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
				wr = 1'b0;
				em.write = 1'b1;
				em.addr = regs[31] + imm;
				em.width = rv_isa_pkg::mem_width_e'(f3[1:0]);
				em.wdata = regs[rs2];
				store_pending = 1'b1;
				store_idx = em.addr[9:2];
				store_word = store_merge(mem[store_idx], regs[rs2], f3[1:0], em.addr[1:0]);
			end
			rv_isa_pkg::OPC_BRANCH: begin
				if (f3[2:1] == 2'b01) begin
					f3[1] = 1'b0;
				end
				imm = {{19{rnd[11]}}, rnd[11:0], 1'b0};
				imm[1] = 1'b0;
				inst_i = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
				wr = 1'b0;
				if (branch_taken(f3, regs[rs1], regs[rs2])) begin
					ew.npc = model_pc + imm;
				end
			end
			rv_isa_pkg::OPC_JAL: begin
				imm = {{11{rnd[19]}}, rnd, 1'b0};
				imm[1] = 1'b0;
				inst_i = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
				res = model_pc + 32'd4;
				ew.npc = model_pc + imm;
			end
			rv_isa_pkg::OPC_JALR: begin
				rs1 = 5'd31;
				imm[1:0] = 2'b00;
				inst_i = {imm[11:0], rs1, 3'b000, rd, opc};
				res = model_pc + 32'd4;
				ew.npc = (regs[31] + imm) & ~32'd1;
			end
			default: begin
				inst_i = {imm[11:0], rs1, f3, rd, opc}; // SYSTEM writes zero
			end
		endcase

		ew.en = wr && (rd != 5'd0);
		ew.rd = rd;
		ew.data = res;
		if (ew.en) begin
			regs[rd] = res;
		end
		pc_i = model_pc;
		inst_valid_i = 1'b1;
		model_pc = ew.npc;
		exp_wb_q.push_back(ew);
		exp_mem_q.push_back(em);
	endtask

	initial begin
		rv_core_pkg::wb_t      idle_wb;
		rv_core_pkg::mem_req_t idle_mem;

		clk_i = 1'b0;
		arst_n_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		pc_i = '0;
		mem_rdata_i = '0;
		model_pc = 32'h0000_1000;
		store_pending = 1'b0;
		store_idx = '0;
		store_word = '0;
		idle_wb = '0;
		idle_mem = '0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i + 1) * 32'h9e3779b9;
		end

		#1;
		arst_n_i = 1'b0; // A clean falling edge starts the asynchronous reset
		repeat (4) @(posedge clk_i);
		#0.5;
		arst_n_i = 1'b1;

		for (int n = 0; n <= NUM_INST; n++) begin
			@(posedge clk_i);
			#0.5;
			if (store_pending) begin
				mem[store_idx] = store_word; // The store is now in stage two
				store_pending = 1'b0;
			end
			mem_rdata_i = mem[mem_req_o.addr[9:2]];
			if (n < NUM_INST) begin
				issue_random_inst();
			end else begin
				inst_valid_i = 1'b0;
			end
			#1;
			if (n == 0) begin
				check_wb(idle_wb, wb_o);
				check_mem(idle_mem, mem_req_o);
			end else begin
				check_wb(exp_wb_q.pop_front(), wb_o);
				check_mem(exp_mem_q.pop_front(), mem_req_o);
			end
			if (u_dut.u_assertions.fail_count != 0) begin
				stop_with_failure("A concurrent assertion on the DUT outputs failed");
			end
		end

		if (u_dut.u_assertions.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/rv_exec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_assertions (
	input wire                        clk_i,
	input wire                        arst_n_i,
	input wire rv_core_pkg::mem_req_t mem_req_i,
	input wire rv_core_pkg::wb_t      wb_i
);

	int unsigned fail_count = 0;

	rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(mem_req_i.read && mem_req_i.write))
	else begin
		fail_count++;
		$error("Memory read and write are both high");
	end

	store_no_rf_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		mem_req_i.write |-> !wb_i.en)
	else begin
		fail_count++;
		$error("Store reported a register write");
	end

	npc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb_i.valid |-> (wb_i.npc[1:0] == 2'b00))
	else begin
		fail_count++;
		$error("Next pc is not word aligned");
	end

	// Nothing may leave the slice while reset is held
	idle_in_reset: assert property (@(posedge clk_i)
		!arst_n_i |-> (!wb_i.valid && !mem_req_i.read && !mem_req_i.write))
	else begin
		fail_count++;
		$error("Writeback or memory request active during reset");
	end

endmodule

`default_nettype wire

//--- hdl/rv_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core (
	input  wire                   clk_i,
	input  wire                   arst_n_i,
	input  wire                   inst_valid_i,
	input  wire  [31:0]           inst_i,
	input  wire  [31:0]           pc_i,
	input  wire  [31:0]           mem_rdata_i,
	output rv_core_pkg::mem_req_t mem_req_o,
	output rv_core_pkg::wb_t      wb_o
);

	rv_isa_pkg::inst_t      inst;
	rv_core_pkg::ctrl_t     ctrl;
	logic [31:0]            imm;
	logic [31:0]            rf_rs1;
	logic [31:0]            rf_rs2;
	logic [31:0]            rs1_val;
	logic [31:0]            rs2_val;
	logic [31:0]            alu_res;
	logic [31:0]            npc;
	rv_core_pkg::ex_stage_t ex_d;
	rv_core_pkg::ex_stage_t ex_q;
	logic                   ex_valid_q;
	logic [7:0]             load_byte;
	logic [15:0]            load_half;
	logic [31:0]            load_data;
	logic [31:0]            wb_data;
	logic                   wb_en;

	assign inst = rv_isa_pkg::inst_t'(inst_i);

	rv_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	rv_imm_gen u_imm_gen (
		.inst_i (inst_i),
		.imm_o  (imm)
	);

	rv_regfile u_regfile (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.rs1_addr_i (inst.rs1),
		.rs2_addr_i (inst.rs2),
		.rs1_data_o (rf_rs1),
		.rs2_data_o (rf_rs2),
		.wr_en_i    (wb_en),
		.wr_addr_i  (ex_q.rd),
		.wr_data_i  (wb_data)
	);

	// Stage two writes at the coming edge, so its value bypasses the register file
	assign rs1_val = (ctrl.rs1_valid && wb_en && (ex_q.rd == inst.rs1)) ? wb_data : rf_rs1;
	assign rs2_val = (ctrl.rs2_valid && wb_en && (ex_q.rd == inst.rs2)) ? wb_data : rf_rs2;

	rv_alu u_alu (
		.ctrl_i   (ctrl),
		.pc_i     (pc_i),
		.rs1_i    (rs1_val),
		.rs2_i    (rs2_val),
		.imm_i    (imm),
		.result_o (alu_res)
	);

	rv_branch_unit u_branch_unit (
		.ctrl_i    (ctrl),
		.pc_i      (pc_i),
		.rs1_i     (rs1_val),
		.rs2_i     (rs2_val),
		.imm_i     (imm),
		.alu_sum_i (alu_res),
		.npc_o     (npc)
	);

	always_comb begin
		ex_d.ctrl    = ctrl;
		ex_d.rd      = inst.rd;
		ex_d.alu_res = alu_res;
		ex_d.rs2     = rs2_val; // Stores send rs2 unshifted
		ex_d.link    = pc_i + 32'd4;
		ex_d.npc     = npc;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_valid_q <= 1'b0;
		end else begin
			ex_valid_q <= inst_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (inst_valid_i) begin
			ex_q <= ex_d;
		end
	end

	// The memory returns the whole aligned word
	assign load_byte = mem_rdata_i[{ex_q.alu_res[1:0], 3'b000} +: 8];
	assign load_half = ex_q.alu_res[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

	always_comb begin
		case (ex_q.ctrl.mem_width)
			rv_isa_pkg::MW_BYTE: begin
				load_data = {{24{ex_q.ctrl.mem_sign & load_byte[7]}}, load_byte};
			end
			rv_isa_pkg::MW_HALF: begin
				load_data = {{16{ex_q.ctrl.mem_sign & load_half[15]}}, load_half};
			end
			default: begin
				load_data = mem_rdata_i;
			end
		endcase
	end

	always_comb begin
		case (ex_q.ctrl.wb_src)
			rv_core_pkg::WB_ALU:  wb_data = ex_q.alu_res;
			rv_core_pkg::WB_MEM:  wb_data = load_data;
			rv_core_pkg::WB_ZERO: wb_data = '0;
			default:              wb_data = ex_q.link;
		endcase
	end

	assign wb_en = ex_valid_q && ex_q.ctrl.rf_wr_en && (ex_q.rd != 5'd0);

	always_comb begin
		mem_req_o.read  = ex_valid_q && ex_q.ctrl.mem_read;
		mem_req_o.write = ex_valid_q && ex_q.ctrl.mem_write;
		mem_req_o.width = ex_q.ctrl.mem_width;
		mem_req_o.sign  = ex_q.ctrl.mem_sign;
		mem_req_o.addr  = ex_q.alu_res;
		mem_req_o.wdata = ex_q.rs2;
	end

	always_comb begin
		wb_o.valid = ex_valid_q;
		wb_o.en    = wb_en;
		wb_o.rd    = ex_q.rd;
		wb_o.data  = wb_data;
		wb_o.npc   = ex_q.npc;
	end

endmodule

`default_nettype wire

//--- hdl/rv_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_branch_unit (
	input  wire rv_core_pkg::ctrl_t ctrl_i,
	input  wire  [31:0]             pc_i,
	input  wire  [31:0]             rs1_i,
	input  wire  [31:0]             rs2_i,
	input  wire  [31:0]             imm_i,
	input  wire  [31:0]             alu_sum_i,
	output logic [31:0]             npc_o
);

	logic        taken;
	logic [31:0] target;

	always_comb begin
		case (ctrl_i.branch_op)
			rv_isa_pkg::F3_BEQ:  taken = (rs1_i == rs2_i);
			rv_isa_pkg::F3_BNE:  taken = (rs1_i != rs2_i);
			rv_isa_pkg::F3_BLT:  taken = ($signed(rs1_i) < $signed(rs2_i));
			rv_isa_pkg::F3_BGE:  taken = ($signed(rs1_i) >= $signed(rs2_i));
			rv_isa_pkg::F3_BLTU: taken = (rs1_i < rs2_i);
			rv_isa_pkg::F3_BGEU: taken = (rs1_i >= rs2_i);
			default:             taken = 1'b0; // BR_NONE for everything but branches
		endcase
	end

	assign target = pc_i + imm_i;

	always_comb begin
		if (ctrl_i.jump) begin
			if (ctrl_i.a_src == rv_core_pkg::A_PC) begin
				npc_o = target; // JAL
			end else begin
				npc_o = {alu_sum_i[31:1], 1'b0}; // JALR
			end
		end else if (taken) begin
			npc_o = target;
		end else begin
			npc_o = pc_i + 32'd4;
		end
	end

endmodule

`default_nettype wire

//--- hdl/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  wire rv_core_pkg::ctrl_t ctrl_i,
	input  wire  [31:0]             pc_i,
	input  wire  [31:0]             rs1_i,
	input  wire  [31:0]             rs2_i,
	input  wire  [31:0]             imm_i,
	output logic [31:0]             result_o
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [4:0]  shamt;

	always_comb begin
		case (ctrl_i.a_src)
			rv_core_pkg::A_RS1:  op_a = rs1_i;
			rv_core_pkg::A_ZERO: op_a = '0;
			default:             op_a = pc_i; // Jumps, AUIPC and branches
		endcase
	end

	// The immediate generator already picked the format, so every immediate source is one path
	assign op_b  = (ctrl_i.b_src == rv_core_pkg::B_RS2) ? rs2_i : imm_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl_i.alu_op)
			rv_core_pkg::ALU_ADD:    result_o = op_a + op_b;
			rv_core_pkg::ALU_SUB:    result_o = op_a - op_b;
			rv_core_pkg::ALU_SLL:    result_o = op_a << shamt;
			rv_core_pkg::ALU_SRL:    result_o = op_a >> shamt;
			rv_core_pkg::ALU_SRA:    result_o = $unsigned($signed(op_a) >>> shamt);
			rv_core_pkg::ALU_SLT:    result_o = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_core_pkg::ALU_SLTU:   result_o = {31'b0, op_a < op_b};
			rv_core_pkg::ALU_XOR:    result_o = op_a ^ op_b;
			rv_core_pkg::ALU_OR:     result_o = op_a | op_b;
			rv_core_pkg::ALU_AND:    result_o = op_a & op_b;
			rv_core_pkg::ALU_PASS_B: result_o = op_b; // LUI
			default:                 result_o = op_a + op_b;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire  [4:0]  rs1_addr_i,
	input  wire  [4:0]  rs2_addr_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o,
	input  wire         wr_en_i,
	input  wire  [4:0]  wr_addr_i,
	input  wire  [31:0] wr_data_i
);

	logic [31:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	always_comb begin
		if (rs1_addr_i == 5'd0) begin
			rs1_data_o = '0;
		end else begin
			rs1_data_o = regs[rs1_addr_i];
		end
	end

	always_comb begin
		if (rs2_addr_i == 5'd0) begin
			rs2_data_o = '0;
		end else begin
			rs2_data_o = regs[rs2_addr_i];
		end
	end

endmodule

`default_nettype wire

//--- hdl/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
	input  wire  [31:0] inst_i,
	output logic [31:0] imm_o
);

	rv_isa_pkg::opcode_e opcode;

	assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);

	always_comb begin
		case (opcode)
			rv_isa_pkg::OPC_STORE: begin
				imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
			end
			rv_isa_pkg::OPC_BRANCH: begin
				imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
					inst_i[11:8], 1'b0};
			end
			rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
				imm_o = {inst_i[31:12], 12'b0};
			end
			rv_isa_pkg::OPC_JAL: begin
				imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
					inst_i[30:21], 1'b0};
			end
			default: begin
				imm_o = {{20{inst_i[31]}}, inst_i[31:20]}; // I format for loads, JALR, OP_IMM
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  wire [31:0]         inst_i,
	output rv_core_pkg::ctrl_t ctrl_o
);

	rv_isa_pkg::inst_t   inst;
	rv_isa_pkg::opcode_e opcode;
	logic                alt_op;

	assign inst   = rv_isa_pkg::inst_t'(inst_i);
	assign opcode = rv_isa_pkg::opcode_e'(inst.opcode);

	// Immediate shifts keep funct7 bit 5, other immediates drop it
	assign alt_op = inst.funct7[5] && ((inst.funct3 == rv_isa_pkg::F3_SRL_SRA) ||
		((opcode == rv_isa_pkg::OPC_OP) && (inst.funct3 == rv_isa_pkg::F3_ADD_SUB)));

	always_comb begin
		ctrl_o           = '0;
		ctrl_o.branch_op = rv_core_pkg::BR_NONE;
		ctrl_o.alu_op    = rv_core_pkg::ALU_ADD;
		ctrl_o.a_src     = rv_core_pkg::A_RS1;
		ctrl_o.b_src     = rv_core_pkg::B_RS2;
		ctrl_o.wb_src    = rv_core_pkg::WB_ALU;
		ctrl_o.rs1_valid = 1'b1;
		ctrl_o.rf_wr_en  = 1'b1;
		ctrl_o.mem_sign  = ~inst.funct3[2]; // Set for LB and LH
		ctrl_o.mem_width = rv_isa_pkg::mem_width_e'(inst.funct3[1:0]);

		case (opcode)
			rv_isa_pkg::OPC_LOAD: begin
				ctrl_o.b_src    = rv_core_pkg::B_IMM_I;
				ctrl_o.wb_src   = rv_core_pkg::WB_MEM;
				ctrl_o.mem_read = 1'b1;
			end
			rv_isa_pkg::OPC_STORE: begin
				ctrl_o.b_src     = rv_core_pkg::B_IMM_S;
				ctrl_o.rs2_valid = 1'b1;
				ctrl_o.rf_wr_en  = 1'b0;
				ctrl_o.mem_write = 1'b1;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				ctrl_o.branch_op = inst.funct3;
				ctrl_o.a_src     = rv_core_pkg::A_PC_BR;
				ctrl_o.b_src     = rv_core_pkg::B_IMM_OTHER;
				ctrl_o.rs2_valid = 1'b1;
				ctrl_o.rf_wr_en  = 1'b0;
			end
			rv_isa_pkg::OPC_JAL: begin
				ctrl_o.jump      = 1'b1;
				ctrl_o.a_src     = rv_core_pkg::A_PC;
				ctrl_o.b_src     = rv_core_pkg::B_IMM_OTHER;
				ctrl_o.rs1_valid = 1'b0;
				ctrl_o.wb_src    = rv_core_pkg::WB_LINK;
			end
			rv_isa_pkg::OPC_JALR: begin
				ctrl_o.jump   = 1'b1;
				ctrl_o.b_src  = rv_core_pkg::B_IMM_I;
				ctrl_o.wb_src = rv_core_pkg::WB_LINK;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				ctrl_o.alu_op = rv_core_pkg::alu_op_e'({alt_op, inst.funct3});
				ctrl_o.b_src  = rv_core_pkg::B_IMM_I;
			end
			rv_isa_pkg::OPC_OP: begin
				ctrl_o.alu_op    = rv_core_pkg::alu_op_e'({alt_op, inst.funct3});
				ctrl_o.rs2_valid = 1'b1;
			end
			rv_isa_pkg::OPC_LUI: begin
				ctrl_o.alu_op    = rv_core_pkg::ALU_PASS_B;
				ctrl_o.a_src     = rv_core_pkg::A_ZERO;
				ctrl_o.b_src     = rv_core_pkg::B_IMM_OTHER;
				ctrl_o.rs1_valid = 1'b0;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				ctrl_o.a_src     = rv_core_pkg::A_PC;
				ctrl_o.b_src     = rv_core_pkg::B_IMM_OTHER;
				ctrl_o.rs1_valid = 1'b0;
			end
			rv_isa_pkg::OPC_SYSTEM: begin
				ctrl_o.wb_src = rv_core_pkg::WB_ZERO;
			end
			default: begin
				ctrl_o.rs1_valid = 1'b0; // Unknown opcodes leave no trace
				ctrl_o.rf_wr_en  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SLL    = 4'b0001,
		ALU_SLT    = 4'b0010,
		ALU_SLTU   = 4'b0011,
		ALU_XOR    = 4'b0100,
		ALU_SRL    = 4'b0101,
		ALU_OR     = 4'b0110,
		ALU_AND    = 4'b0111,
		ALU_SUB    = 4'b1000,
		ALU_SRA    = 4'b1101,
		ALU_PASS_B = 4'b1111
	} alu_op_e;

	typedef enum logic [1:0] {A_RS1, A_ZERO, A_PC, A_PC_BR} a_src_e;
	typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_OTHER} b_src_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_ZERO, WB_LINK} wb_src_e;

	localparam logic [2:0] BR_NONE = 3'b010; // Not a branch funct3, never taken

	typedef struct packed {
		logic                   jump;
		logic [2:0]             branch_op;
		alu_op_e                alu_op;
		a_src_e                 a_src;
		b_src_e                 b_src;
		logic                   rs1_valid;
		logic                   rs2_valid;
		logic                   rf_wr_en;
		wb_src_e                wb_src;
		logic                   mem_read;
		logic                   mem_write;
		logic                   mem_sign;
		rv_isa_pkg::mem_width_e mem_width;
	} ctrl_t;

	typedef struct packed {
		logic                   read;
		logic                   write;
		rv_isa_pkg::mem_width_e width;
		logic                   sign;
		logic [31:0]            addr;
		logic [31:0]            wdata;
	} mem_req_t;

	typedef struct packed {
		logic        valid;
		logic        en;
		logic [4:0]  rd;
		logic [31:0] data;
		logic [31:0] npc;
	} wb_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [4:0]  rd;
		logic [31:0] alu_res;
		logic [31:0] rs2;
		logic [31:0] link;
		logic [31:0] npc;
	} ex_stage_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_f3_e;

	typedef enum logic [1:0] {
		MW_BYTE = 2'b00,
		MW_HALF = 2'b01,
		MW_WORD = 2'b10
	} mem_width_e;

	localparam logic [2:0] F3_ADD_SUB = 3'b000; // funct7 bit 5 picks SUB in OP only
	localparam logic [2:0] F3_SRL_SRA = 3'b101; // funct7 bit 5 picks SRA in OP and OP_IMM

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_t;

endpackage

`default_nettype wire
